//--- hdl/rv_alu.sv
`timescale 1ns/100ps

module rv_alu (
  input  rv_pkg::alu_op_t         op,
  input  logic [rv_pkg::xlen-1:0] a,
  input  logic [rv_pkg::xlen-1:0] b,
  input  logic [2:0]              cond,
  input  logic [rv_pkg::xlen-1:0] rs1_data,
  input  logic [rv_pkg::xlen-1:0] rs2_data,
  output logic [rv_pkg::xlen-1:0] result,
  output logic                    taken
);

  logic [4:0] shamt;
  logic       br_eq;
  logic       br_lt;
  logic       br_ltu;

  // Shift amount from low five bits of either register or immediate
  assign shamt = b[4:0];

  // ----------------------------------------------------------
  // Integer operations
  // ----------------------------------------------------------
  always_comb begin
    case (op)
      rv_pkg::alu_add:  result = a + b;
      rv_pkg::alu_sub:  result = a - b;
      rv_pkg::alu_sll:  result = a << shamt;
      rv_pkg::alu_slt:  result = {31'b0, $signed(a) < $signed(b)};
      rv_pkg::alu_sltu: result = {31'b0, a < b};
      rv_pkg::alu_xor:  result = a ^ b;
      rv_pkg::alu_srl:  result = a >> shamt;
      // Arithmetic shift keeps the sign bit
      rv_pkg::alu_sra:  result = $signed(a) >>> shamt;
      rv_pkg::alu_or:   result = a | b;
      rv_pkg::alu_and:  result = a & b;
      default:          result = '0;
    endcase
  end

  // ----------------------------------------------------------
  // Branch comparator, always on the two register values
  // ----------------------------------------------------------
  assign br_eq  = (rs1_data == rs2_data);
  assign br_lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign br_ltu = (rs1_data < rs2_data);

  always_comb begin
    case (cond)
      rv_pkg::f3_beq:  taken = br_eq;
      rv_pkg::f3_bne:  taken = !br_eq;
      rv_pkg::f3_blt:  taken = br_lt;
      rv_pkg::f3_bge:  taken = !br_lt;
      rv_pkg::f3_bltu: taken = br_ltu;
      rv_pkg::f3_bgeu: taken = !br_ltu;
      // 010 and 011 are not branch codes
      default:         taken = 1'b0;
    endcase
  end

endmodule

//--- hdl/rv_core.sv
`timescale 1ns/100ps

module rv_core (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       run,
  input  logic                       imem_we,
  input  logic [rv_pkg::imem_aw-1:0] imem_addr,
  input  logic [rv_pkg::xlen-1:0]    imem_wdata,
  output logic [rv_pkg::xlen-1:0]    pc,
  output logic                       wb_en,
  output logic [rv_pkg::reg_aw-1:0]  wb_rd,
  output logic [rv_pkg::xlen-1:0]    wb_data,
  output logic                       ebreak
);

  // ----------------------------------------------------------
  // Internal wiring
  // ----------------------------------------------------------
  logic [rv_pkg::xlen-1:0]   instr;
  logic                      pc_sel_jump;
  logic [rv_pkg::xlen-1:0]   jump_target;
  logic [rv_pkg::reg_aw-1:0] rs1;
  logic [rv_pkg::reg_aw-1:0] rs2;
  logic [rv_pkg::xlen-1:0]   rs1_data;
  logic [rv_pkg::xlen-1:0]   rs2_data;
  rv_pkg::alu_op_t           alu_op;
  logic [rv_pkg::xlen-1:0]   alu_a;
  logic [rv_pkg::xlen-1:0]   alu_b;
  logic [2:0]                cond;
  logic [rv_pkg::xlen-1:0]   alu_result;
  logic                      taken;

  // PC and instruction memory
  rv_fetch fetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (run),
    .imem_we    (imem_we),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .pc_sel_jump(pc_sel_jump),
    .jump_target(jump_target),
    .pc         (pc),
    .instr      (instr)
  );

  // Write port is the same commit that the trace shows
  rv_regfile regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs1     (rs1),
    .rs2     (rs2),
    .wr_en   (wb_en),
    .rd      (wb_rd),
    .wr_data (wb_data),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  rv_alu alu (
    .op      (alu_op),
    .a       (alu_a),
    .b       (alu_b),
    .cond    (cond),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .result  (alu_result),
    .taken   (taken)
  );

  // Control
  rv_decoder decoder (
    .run        (run),
    .instr      (instr),
    .pc         (pc),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .alu_result (alu_result),
    .taken      (taken),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (wb_rd),
    .alu_op     (alu_op),
    .alu_a      (alu_a),
    .alu_b      (alu_b),
    .cond       (cond),
    .wb_en      (wb_en),
    .wb_data    (wb_data),
    .pc_sel_jump(pc_sel_jump),
    .jump_target(jump_target),
    .ebreak     (ebreak)
  );

endmodule

//--- hdl/rv_decoder.sv
`timescale 1ns/100ps

module rv_decoder (
  input  logic                      run,
  input  logic [rv_pkg::xlen-1:0]   instr,
  input  logic [rv_pkg::xlen-1:0]   pc,
  input  logic [rv_pkg::xlen-1:0]   rs1_data,
  input  logic [rv_pkg::xlen-1:0]   rs2_data,
  input  logic [rv_pkg::xlen-1:0]   alu_result,
  input  logic                      taken,
  output logic [rv_pkg::reg_aw-1:0] rs1,
  output logic [rv_pkg::reg_aw-1:0] rs2,
  output logic [rv_pkg::reg_aw-1:0] rd,
  output rv_pkg::alu_op_t           alu_op,
  output logic [rv_pkg::xlen-1:0]   alu_a,
  output logic [rv_pkg::xlen-1:0]   alu_b,
  output logic [2:0]                cond,
  output logic                      wb_en,
  output logic [rv_pkg::xlen-1:0]   wb_data,
  output logic                      pc_sel_jump,
  output logic [rv_pkg::xlen-1:0]   jump_target,
  output logic                      ebreak
);

  rv_pkg::rv_instr_t ins;

  logic [rv_pkg::xlen-1:0] imm_i;
  logic [rv_pkg::xlen-1:0] imm_b;
  logic [rv_pkg::xlen-1:0] imm_u;
  logic [rv_pkg::xlen-1:0] imm_j;
  logic [rv_pkg::xlen-1:0] pc_off;
  logic [rv_pkg::xlen-1:0] pc_imm;
  logic [rv_pkg::xlen-1:0] pc_plus4;
  logic [rv_pkg::xlen-1:0] jalr_sum;
  logic                    is_reg_op;
  logic                    wb_req;
  logic                    jump_req;
  logic                    ebreak_req;

  assign ins = instr;

  // Register fields sit in the same place in every format
  assign rs1  = ins.r.rs1;
  assign rs2  = ins.r.rs2;
  assign rd   = ins.r.rd;
  assign cond = ins.r.funct3;

  // ----------------------------------------------------------
  // Immediates, all sign-extended from bit 31
  // ----------------------------------------------------------
  assign imm_i = {{20{ins.i.imm[11]}}, ins.i.imm};
  // B: imm_hi holds [12|10:5], imm_lo holds [4:1|11]
  assign imm_b = {{20{ins.sb.imm_hi[6]}}, ins.sb.imm_lo[0], ins.sb.imm_hi[5:0],
                  ins.sb.imm_lo[4:1], 1'b0};
  assign imm_u = {ins.uj.imm, 12'b0};
  // J: field holds [20|10:1|11|19:12]
  assign imm_j = {{12{ins.uj.imm[19]}}, ins.uj.imm[7:0], ins.uj.imm[8],
                  ins.uj.imm[18:9], 1'b0};

  // ----------------------------------------------------------
  // Address arithmetic
  // ----------------------------------------------------------
  // One PC-relative adder serves AUIPC, JAL and branches
  always_comb begin
    case (ins.r.opcode)
      rv_pkg::opc_auipc: pc_off = imm_u;
      rv_pkg::opc_jal:   pc_off = imm_j;
      default:           pc_off = imm_b;
    endcase
  end

  assign pc_imm   = pc + pc_off;
  assign pc_plus4 = pc + rv_pkg::xlen'(4);
  assign jalr_sum = rs1_data + imm_i;

  // JALR target has bit 0 forced low
  assign jump_target = (ins.r.opcode == rv_pkg::opc_jalr) ? {jalr_sum[31:1], 1'b0} : pc_imm;

  // ----------------------------------------------------------
  // ALU operation from funct3
  // ----------------------------------------------------------
  assign is_reg_op = (ins.r.opcode == rv_pkg::opc_op);

  always_comb begin
    case (ins.r.funct3)
      // SUB only exists in the register form
      rv_pkg::f3_add:  alu_op = (is_reg_op && ins.r.funct7[5]) ? rv_pkg::alu_sub
                                                                : rv_pkg::alu_add;
      rv_pkg::f3_sll:  alu_op = rv_pkg::alu_sll;
      rv_pkg::f3_slt:  alu_op = rv_pkg::alu_slt;
      rv_pkg::f3_sltu: alu_op = rv_pkg::alu_sltu;
      rv_pkg::f3_xor:  alu_op = rv_pkg::alu_xor;
      // SRAI carries the same funct7 bit inside its immediate
      rv_pkg::f3_srl:  alu_op = ins.r.funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      rv_pkg::f3_or:   alu_op = rv_pkg::alu_or;
      default:         alu_op = rv_pkg::alu_and;
    endcase
  end

  // Operand a is always rs1, b is the register or the I immediate
  assign alu_a = rs1_data;
  assign alu_b = is_reg_op ? rs2_data : imm_i;

  // ----------------------------------------------------------
  // Write-back source and next-PC source
  // ----------------------------------------------------------
  always_comb begin
    wb_req     = 1'b0;
    wb_data    = alu_result;
    jump_req   = 1'b0;
    ebreak_req = 1'b0;
    case (ins.r.opcode)
      rv_pkg::opc_op_imm,
      rv_pkg::opc_op: begin
        wb_req = 1'b1;
      end
      rv_pkg::opc_lui: begin
        wb_req  = 1'b1;
        wb_data = imm_u;
      end
      rv_pkg::opc_auipc: begin
        wb_req  = 1'b1;
        wb_data = pc_imm;
      end
      // Both jumps link to the next sequential address
      rv_pkg::opc_jal,
      rv_pkg::opc_jalr: begin
        wb_req   = 1'b1;
        wb_data  = pc_plus4;
        jump_req = 1'b1;
      end
      rv_pkg::opc_branch: begin
        jump_req = taken;
      end
      rv_pkg::opc_system: begin
        ebreak_req = (instr == rv_pkg::ebreak_word);
      end
      // Anything else falls through as a no-op
      default: begin
        wb_req = 1'b0;
      end
    endcase
  end

  // Nothing takes effect while idle, writes to x0 are dropped here
  assign wb_en       = run && wb_req && (ins.r.rd != '0);
  assign pc_sel_jump = run && jump_req;
  assign ebreak      = run && ebreak_req;

endmodule

//--- hdl/rv_fetch.sv
`timescale 1ns/100ps

module rv_fetch (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       run,
  input  logic                       imem_we,
  input  logic [rv_pkg::imem_aw-1:0] imem_addr,
  input  logic [rv_pkg::xlen-1:0]    imem_wdata,
  input  logic                       pc_sel_jump,
  input  logic [rv_pkg::xlen-1:0]    jump_target,
  output logic [rv_pkg::xlen-1:0]    pc,
  output logic [rv_pkg::xlen-1:0]    instr
);

  // 1024 words, written from outside while the core is idle
  logic [rv_pkg::xlen-1:0] imem [2**rv_pkg::imem_aw];

  logic [rv_pkg::xlen-1:0] pc_next;

  // ----------------------------------------------------------
  // Instruction memory
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_wdata;
    end
  end

  // Asynchronous read, word index taken from the byte PC
  assign instr = imem[pc[rv_pkg::imem_aw+1:2]];

  // ----------------------------------------------------------
  // Program counter
  // ----------------------------------------------------------
  // Sequential or redirected by the decoder
  assign pc_next = pc_sel_jump ? jump_target : pc + rv_pkg::xlen'(4);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (!run) begin
      // Parked at the reset vector while a program is loaded
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

//--- hdl/rv_pkg.sv
package rv_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------
  localparam int xlen    = 32;
  localparam int reg_aw  = 5;
  // Instruction memory word address, 1024 words
  localparam int imem_aw = 10;

  // ----------------------------------------------------------
  // Major opcodes kept by this core
  // ----------------------------------------------------------
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_system = 7'b1110011;

  // ALU funct3 codes, shared by OP and OP-IMM
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_srl  = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // Branch condition codes
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // Only SYSTEM encoding that does anything here
  localparam logic [31:0] ebreak_word = 32'h0010_0073;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_t;

  // ----------------------------------------------------------
  // Instruction word, one view per encoding format
  // ----------------------------------------------------------
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // Store and branch share this split immediate layout
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } sb_fmt_t;

  // Upper immediate and jump share the 20-bit field
  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } uj_fmt_t;

  typedef union packed {
    r_fmt_t  r;
    i_fmt_t  i;
    sb_fmt_t sb;
    uj_fmt_t uj;
  } rv_instr_t;

endpackage

//--- hdl/rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [rv_pkg::reg_aw-1:0] rs1,
  input  logic [rv_pkg::reg_aw-1:0] rs2,
  input  logic                      wr_en,
  input  logic [rv_pkg::reg_aw-1:0] rd,
  input  logic [rv_pkg::xlen-1:0]   wr_data,
  output logic [rv_pkg::xlen-1:0]   rs1_data,
  output logic [rv_pkg::xlen-1:0]   rs2_data
);

  // x1..x31, x0 has no storage
  logic [rv_pkg::xlen-1:0] regs [1:31];

  // Write port, rd of zero never arrives with wr_en set
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[rd] <= wr_data;
    end
  end

  // Combinational reads, x0 reads as zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- tb.f
hdl/rv_pkg.sv
hdl/rv_fetch.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_decoder.sv
hdl/rv_core.sv
testbench/rv_core_assert.sv
testbench/rv_core_tb.sv

//--- testbench/rv_core_assert.sv
`timescale 1ns/100ps

module rv_core_assert (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      run,
  input logic [rv_pkg::xlen-1:0]   pc,
  input logic                      wb_en,
  input logic [rv_pkg::reg_aw-1:0] wb_rd,
  input logic                      ebreak
);

  // ----------------------------------------------------------
  // Trace and control properties
  // ----------------------------------------------------------
  // EBREAK never writes a register
  wb_ebreak_excl: assert property (@(posedge clk) disable iff (!rst_n) !(wb_en && ebreak))
    else $error("wb_en and ebreak high in the same cycle");

  // Writes to x0 are dropped before the trace
  wb_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n) wb_en |-> wb_rd != '0)
    else $error("write-back trace shows x0");

  // No compressed instructions, so the PC stays word-aligned
  pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
    else $error("pc not word-aligned: %h", pc);

  // Idle core has no effects
  idle_quiet: assert property (@(posedge clk) disable iff (!rst_n) !run |-> !wb_en && !ebreak)
    else $error("wb_en or ebreak high while run is low");

endmodule

bind rv_core rv_core_assert core_checks (
  .clk   (clk),
  .rst_n (rst_n),
  .run   (run),
  .pc    (pc),
  .wb_en (wb_en),
  .wb_rd (wb_rd),
  .ebreak(ebreak)
);

//--- testbench/rv_core_tb.sv
`timescale 1ns/100ps

module rv_core_tb;

  // ----------------------------------------------------------
  // DUT signals
  // ----------------------------------------------------------
  logic                       clk;
  logic                       rst_n;
  logic                       run;
  logic                       imem_we;
  logic [rv_pkg::imem_aw-1:0] imem_addr;
  logic [rv_pkg::xlen-1:0]    imem_wdata;
  logic [rv_pkg::xlen-1:0]    pc;
  logic                       wb_en;
  logic [rv_pkg::reg_aw-1:0]  wb_rd;
  logic [rv_pkg::xlen-1:0]    wb_data;
  logic                       ebreak;

  // Test table with one entry per T ... X block of the data file
  string       test_names[$];
  int          prog_start[$];
  int          prog_count[$];
  int          exp_start[$];
  int          exp_count[$];
  logic [31:0] prog_words[$];
  int          exp_rd[$];
  logic [31:0] exp_data[$];

  string cur_test;
  int    cycles = 0;
  int    cycle_limit = 0;

  rv_core uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .run       (run),
    .imem_we   (imem_we),
    .imem_addr (imem_addr),
    .imem_wdata(imem_wdata),
    .pc        (pc),
    .wb_en     (wb_en),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .ebreak    (ebreak)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------------------------
  // Error handling and checks
  // ----------------------------------------------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("FAIL %s %s: expected %h, actual %h",
                          cur_test, what, expected, actual));
    end
  endtask

  // Cycle budget that ends a run which never reaches its EBREAK
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      abort_run($sformatf("Timeout: the run did not finish within %0d cycles", cycle_limit));
    end
  end

  // ----------------------------------------------------------
  // Data file parser
  // ----------------------------------------------------------
  task automatic read_patterns();
    int          fd;
    int          n;
    string       line;
    string       name;
    byte         tag;
    int          rd;
    logic [31:0] word;
    fd = $fopen("testbench/rv_patterns.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open the data file testbench/rv_patterns.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0) begin
        tag = line.getc(0);
        case (tag)
          "T": begin
            n = $sscanf(line, "%c %s", tag, name);
            test_names.push_back(name);
            prog_start.push_back(prog_words.size());
            exp_start.push_back(exp_data.size());
          end
          "P": begin
            n = $sscanf(line, "%c %h", tag, word);
            prog_words.push_back(word);
          end
          "E": begin
            n = $sscanf(line, "%c %d %h", tag, rd, word);
            exp_rd.push_back(rd);
            exp_data.push_back(word);
          end
          // End of test closes both counts
          "X": begin
            prog_count.push_back(prog_words.size() - prog_start[prog_start.size() - 1]);
            exp_count.push_back(exp_data.size() - exp_start[exp_start.size() - 1]);
          end
          default: begin
            // Comments and blank lines
          end
        endcase
      end
    end
    $fclose(fd);
    if (test_names.size() == 0 || prog_count.size() != test_names.size()) begin
      abort_run("The data file holds no tests or a test without its end line");
    end
  endtask

  // ----------------------------------------------------------
  // One test with reset, load and a run until EBREAK
  // ----------------------------------------------------------
  task automatic run_test(input int t);
    int  ei;
    int  k;
    bit  done;
    cur_test = test_names[t];
    @(posedge clk);
    #1 rst_n = 1'b0;
    run = 1'b0;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    compare_value("pc after reset", 32'd0, pc);
    compare_value("ebreak after reset", 32'd0, 32'(ebreak));
    compare_value("wb_en after reset", 32'd0, 32'(wb_en));
    // One word per cycle through the memory port
    for (int i = 0; i < prog_count[t]; i++) begin
      imem_we    = 1'b1;
      imem_addr  = rv_pkg::imem_aw'(i);
      imem_wdata = prog_words[prog_start[t] + i];
      @(negedge clk);
      // Core parked at the reset vector while idle
      compare_value("pc while loading", 32'd0, pc);
      compare_value("ebreak while loading", 32'd0, 32'(ebreak));
      @(posedge clk);
      #1;
    end
    imem_we = 1'b0;
    run     = 1'b1;
    ei      = 0;
    done    = 1'b0;
    // Sample at the falling edge between drive and commit
    while (!done) begin
      @(negedge clk);
      if (wb_en) begin
        if (ei >= exp_count[t]) begin
          abort_run($sformatf("%s: write to x%0d with value %h beyond the expected trace",
                              cur_test, wb_rd, wb_data));
        end else begin
          k = exp_start[t] + ei;
          compare_value($sformatf("write %0d register", ei), 32'(exp_rd[k]), 32'(wb_rd));
          compare_value($sformatf("write %0d data", ei), exp_data[k], wb_data);
          ei++;
        end
      end
      if (ebreak) begin
        done = 1'b1;
      end
      @(posedge clk);
      #1;
    end
    // Every expected write must come before the EBREAK
    compare_value("writes before ebreak", 32'(exp_count[t]), 32'(ei));
    run = 1'b0;
  endtask

  initial begin
    rst_n      = 1'b0;
    run        = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    read_patterns();
    cycle_limit = 8 * (prog_words.size() + exp_data.size()) + 200;
    foreach (test_names[t]) begin
      run_test(t);
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- testbench/rv_patterns.txt
# Columns: T <test name> | P <instruction word, hex> | E <rd, decimal> <value, hex> | X end
# E lines list the write-back trace in commit order, text after a value is a note
T imm_arith
P 02A00093  addi x1, x0, 42
E 1 0000002A
P FCE00113  addi x2, x0, -50
E 2 FFFFFFCE
P 00000193  addi x3, x0, 0
E 3 00000000
P 7FF00213  addi x4, x0, 2047
E 4 000007FF
P 80000293  addi x5, x0, -2048
E 5 FFFFF800
P 00500013  addi x0, x0, 5 (no trace)
P FF808313  addi x6, x1, -8
E 6 00000022
P 00100073  ebreak
X
T reg_ops
P FF000093  addi x1, x0, -16
E 1 FFFFFFF0
P 02500113  addi x2, x0, 37
E 2 00000025
P 002081B3  add x3, x1, x2
E 3 00000015
P 40208233  sub x4, x1, x2
E 4 FFFFFFCB
P 0020F2B3  and x5, x1, x2
E 5 00000020
P 0020E333  or x6, x1, x2
E 6 FFFFFFF5
P 0020C3B3  xor x7, x1, x2
E 7 FFFFFFD5
P 00209433  sll x8, x1, x2
E 8 FFFFFE00
P 0020D4B3  srl x9, x1, x2
E 9 07FFFFFF
P 4020D533  sra x10, x1, x2
E 10 FFFFFFFF
P 0020A5B3  slt x11, x1, x2
E 11 00000001
P 0020B633  sltu x12, x1, x2
E 12 00000000
P 0FF0F693  andi x13, x1, 0xff
E 13 000000F0
P 00F0E713  ori x14, x1, 15
E 14 FFFFFFFF
P FFF0C793  xori x15, x1, -1
E 15 0000000F
P 00409813  slli x16, x1, 4
E 16 FFFFFF00
P 0040D893  srli x17, x1, 4
E 17 0FFFFFFF
P 4020D913  srai x18, x1, 2
E 18 FFFFFFFC
P FF10A993  slti x19, x1, -15
E 19 00000001
P FFF0BA13  sltiu x20, x1, -1
E 20 00000001
P 00100073  ebreak
X
T upper_imm
P 123450B7  lui x1, 0x12345
E 1 12345000
P FFFFF117  auipc x2, 0xfffff at pc 4
E 2 FFFFF004
P 800001B7  lui x3, 0x80000
E 3 80000000
P 00001217  auipc x4, 0x1 at pc 12
E 4 0000100C
P FFFF0297  auipc x5, 0xffff0 at pc 16
E 5 FFFF0010
P 00100073  ebreak
X
T jumps
P 00C000EF  0: jal x1, +12
E 1 00000004
P 00100113  4: skipped
P 00200113  8: skipped
P 02000193  12: addi x3, x0, 32
E 3 00000020
P 00118267  16: jalr x4, 1(x3) lands on 32
E 4 00000014
P 00300113  20: skipped
P 00400113  24: skipped
P 00500113  28: skipped
P 010002EF  32: jal x5, +16 (call)
E 5 00000024
P 00700393  36: addi x7, x0, 7 after return
P 00100073  40: ebreak
P 00600113  44: skipped
P 00600313  48: addi x6, x0, 6
E 6 00000006
P 00028067  52: jalr x0, 0(x5) (return)
E 7 00000007
X
T branches
P FFF00093  addi x1, x0, -1
E 1 FFFFFFFF
P 00100113  addi x2, x0, 1
E 2 00000001
P 00108463  beq x1, x1 taken
P 00100193  skipped
P 00208463  beq x1, x2 not taken
P 00200193  addi x3, x0, 2
E 3 00000002
P 00209463  bne x1, x2 taken
P 00300193  skipped
P 00211463  bne x2, x2 not taken
P 00400193  addi x3, x0, 4
E 3 00000004
P 0020C463  blt x1, x2 taken
P 00500193  skipped
P 00114463  blt x2, x1 not taken
P 00600193  addi x3, x0, 6
E 3 00000006
P 00115463  bge x2, x1 taken
P 00700193  skipped
P 0020D463  bge x1, x2 not taken
P 00800193  addi x3, x0, 8
E 3 00000008
P 00116463  bltu x2, x1 taken
P 00900193  skipped
P 0020E463  bltu x1, x2 not taken
P 00A00193  addi x3, x0, 10
E 3 0000000A
P 0020F463  bgeu x1, x2 taken
P 00B00193  skipped
P 00117463  bgeu x2, x1 not taken
P 00C00193  addi x3, x0, 12
E 3 0000000C
P 00300213  addi x4, x0, 3
P FFF20213  loop: addi x4, x4, -1
P FE021EE3  bne x4, x0, loop
P 00100073  ebreak
E 4 00000003
E 4 00000002
E 4 00000001
E 4 00000000
X
